/* verilog/nlc_pkg.sv */
`default_nettype none

package nlc_pkg;

  localparam int SAMPLE_WIDTH = 21;
  localparam int WORD_WIDTH   = 32;
  localparam int FRAC_BITS    = 16;
  localparam int LANES        = 8;
  localparam int POLY_ORDER   = 10;
  localparam int SECTIONS     = 4;
  localparam int MAC_LATENCY  = 2;

  typedef logic signed [SAMPLE_WIDTH-1:0] sample_t;
  typedef logic signed [WORD_WIDTH-1:0]   word_t;
  typedef logic [1:0]                     section_t;
  typedef logic [2*LANES-1:0]             section_word_t;  // lane 0 in top bits
  typedef logic [$clog2(LANES)-1:0]       lane_t;
  typedef logic [3:0]                     coeff_index_t;
  typedef logic [5:0]                     wb_addr_t;       // section * 16 + index

  localparam word_t FIX_ONE = 32'sd65536;

  // special slots in a calibration set
  localparam coeff_index_t IDX_NEG_MEAN    = 4'd14;
  localparam coeff_index_t IDX_RECIP_STDEV = 4'd15;

  typedef enum logic [1:0] {IDLE, RUN, FLUSH, EMIT} seq_state_t;

endpackage

`default_nettype wire

/* verilog/coeff_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module coeff_regs import nlc_pkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         wb_cyc,
  input  logic         wb_stb,
  input  logic         wb_we,
  input  wb_addr_t     wb_adr,
  input  word_t        wb_dat_w,
  output word_t        wb_dat_r,
  output logic         wb_ack,
  input  section_t     rd_section,
  input  coeff_index_t rd_index,
  output word_t        rd_data
);

  localparam int SET_WORDS = POLY_ORDER + 3;  // coefficients, mean, stdev

  word_t        regs [SECTIONS][SET_WORDS];
  section_t     wb_section;
  coeff_index_t wb_index;

  function automatic logic index_valid(coeff_index_t idx);
    return (idx <= coeff_index_t'(POLY_ORDER)) || (idx >= IDX_NEG_MEAN);
  endfunction

  function automatic int slot(coeff_index_t idx);
    int s;
    if (idx == IDX_NEG_MEAN) s = POLY_ORDER + 1;
    else if (idx == IDX_RECIP_STDEV) s = POLY_ORDER + 2;
    else s = int'(idx);
    return s;
  endfunction

  assign wb_section = wb_adr[5:4];
  assign wb_index   = wb_adr[3:0];

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_ack <= 1'b0;
      for (int s = 0; s < SECTIONS; s++) begin
        for (int w = 0; w < SET_WORDS; w++) begin
          regs[s][w] <= '0;
        end
      end
    end else begin
      wb_ack <= wb_cyc && wb_stb && !wb_ack;  // one wait state
      if (wb_cyc && wb_stb && wb_we && wb_ack && index_valid(wb_index)) begin
        regs[wb_section][slot(wb_index)] <= wb_dat_w;
      end
    end
  end

  always_comb begin
    wb_dat_r = '0;
    rd_data  = '0;
    if (index_valid(wb_index)) wb_dat_r = regs[wb_section][slot(wb_index)];
    if (index_valid(rd_index)) rd_data = regs[rd_section][slot(rd_index)];
  end

endmodule

`default_nettype wire

/* verilog/frame_capture.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_capture import nlc_pkg::*; #(
  parameter int LANES = nlc_pkg::LANES
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          srdyi,
  input  sample_t       x_adc,
  input  section_word_t section_select,
  input  logic          frame_done,
  output logic          ready,
  output logic          frame_full,
  input  lane_t         lane_sel,
  output sample_t       lane_sample,
  output section_t      lane_section
);

  localparam lane_t LAST_LANE = lane_t'(LANES - 1);

  lane_t         count;
  sample_t       sample_buf [LANES];
  section_word_t sections;
  logic          accept;

  assign accept = srdyi && ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      ready      <= 1'b1;
      frame_full <= 1'b0;
      count      <= '0;
    end else begin
      if (frame_done) begin
        ready      <= 1'b1;
        frame_full <= 1'b0;
      end else if (accept && count == LAST_LANE) begin
        ready      <= 1'b0;  // hold off until results are out
        frame_full <= 1'b1;
      end
      if (accept) count <= (count == LAST_LANE) ? '0 : count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      sample_buf[count] <= x_adc;
      if (count == '0) sections <= section_select;  // taken with first sample
    end
  end

  assign lane_sample  = sample_buf[lane_sel];
  assign lane_section = sections[2*(LANES-1-int'(lane_sel)) +: 2];

endmodule

`default_nettype wire

/* verilog/mul_add_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module mul_add_unit import nlc_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  logic  in_valid,
  input  word_t in_a,
  input  word_t in_b,
  input  word_t in_c,
  input  lane_t in_lane,
  input  logic  in_to_norm,
  output logic  out_valid,
  output word_t out_res,
  output lane_t out_lane,
  output logic  out_to_norm
);

  logic signed [2*WORD_WIDTH-1:0] prod;
  word_t                          c_d;
  lane_t                          lane_d;
  logic                           valid_d;
  logic                           to_norm_d;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_d   <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      valid_d   <= in_valid;
      out_valid <= valid_d;
    end
  end

  always_ff @(posedge clk) begin
    prod        <= in_a * in_b;  // full width product
    c_d         <= in_c;
    lane_d      <= in_lane;
    to_norm_d   <= in_to_norm;
    out_res     <= word_t'(prod >>> FRAC_BITS) + c_d;  // wraps
    out_lane    <= lane_d;
    out_to_norm <= to_norm_d;
  end

endmodule

`default_nettype wire

/* verilog/lane_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module lane_regs import nlc_pkg::*; #(
  parameter int LANES = nlc_pkg::LANES
) (
  input  logic  clk,
  input  logic  wr_valid,
  input  logic  wr_to_norm,
  input  lane_t wr_lane,
  input  word_t wr_data,
  input  lane_t rd_lane,
  output word_t acc,
  output word_t norm,
  input  lane_t out_lane,
  output word_t out_acc
);

  word_t acc_mem  [LANES];
  word_t norm_mem [LANES];

  always_ff @(posedge clk) begin
    if (wr_valid) begin
      if (wr_to_norm) begin
        norm_mem[wr_lane] <= wr_data;  // scale pass only
      end else begin
        acc_mem[wr_lane] <= wr_data;
      end
    end
  end

  // sequencer side
  assign acc  = acc_mem[rd_lane];
  assign norm = norm_mem[rd_lane];

  // output side
  assign out_acc = acc_mem[out_lane];

endmodule

`default_nettype wire

/* verilog/horner_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module horner_sequencer import nlc_pkg::*; #(
  parameter int LANES      = nlc_pkg::LANES,
  parameter int POLY_ORDER = nlc_pkg::POLY_ORDER
) (
  input  logic         clk,
  input  logic         reset,
  input  logic         frame_full,
  input  sample_t      lane_sample,
  input  word_t        coeff,
  input  word_t        acc,
  input  word_t        norm,
  input  logic         emit_done,
  output lane_t        lane_sel,
  output coeff_index_t coeff_index,
  output logic         mac_valid,
  output logic         mac_to_norm,
  output word_t        mac_a,
  output word_t        mac_b,
  output word_t        mac_c,
  output lane_t        mac_lane,
  output logic         start_emit,
  output logic         frame_done
);

  localparam int    PASSES    = POLY_ORDER + 3;  // centre, scale, load, horner
  localparam int    PASS_W    = $clog2(PASSES);
  localparam int    FLUSH_W   = $clog2(MAC_LATENCY + 1);
  localparam lane_t LAST_LANE = lane_t'(LANES - 1);

  seq_state_t          state;
  logic [PASS_W-1:0]   pass_cnt;
  lane_t               lane_cnt;
  logic [FLUSH_W-1:0]  flush_cnt;

  assign start_emit = (state == FLUSH) && (flush_cnt == FLUSH_W'(MAC_LATENCY - 1));
  assign frame_done = (state == EMIT) && emit_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= IDLE;
      pass_cnt  <= '0;
      lane_cnt  <= '0;
      flush_cnt <= '0;
    end else begin
      case (state)
        IDLE: begin
          pass_cnt <= '0;
          lane_cnt <= '0;
          if (frame_full) state <= RUN;
        end
        RUN: begin
          if (lane_cnt == LAST_LANE) begin
            lane_cnt <= '0;
            pass_cnt <= pass_cnt + 1'b1;
            if (pass_cnt == PASS_W'(PASSES - 1)) begin
              state     <= FLUSH;
              flush_cnt <= '0;
            end
          end else begin
            lane_cnt <= lane_cnt + 1'b1;
          end
        end
        FLUSH: begin
          flush_cnt <= flush_cnt + 1'b1;  // drain the multiply-add pipe
          if (start_emit) state <= EMIT;
        end
        EMIT: begin
          if (emit_done) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_comb begin
    lane_sel    = lane_cnt;
    mac_lane    = lane_cnt;
    mac_valid   = (state == RUN);
    mac_to_norm = 1'b0;
    mac_a       = acc;  // horner step by default
    mac_b       = norm;
    mac_c       = coeff;
    coeff_index = coeff_index_t'(POLY_ORDER + 2 - int'(pass_cnt));
    case (int'(pass_cnt))
      0: begin  // centre
        coeff_index = IDX_NEG_MEAN;
        mac_a       = word_t'(lane_sample);
        mac_b       = FIX_ONE;
      end
      1: begin  // scale
        coeff_index = IDX_RECIP_STDEV;
        mac_b       = coeff;
        mac_c       = '0;
        mac_to_norm = 1'b1;
      end
      2: begin  // load top coefficient
        coeff_index = coeff_index_t'(POLY_ORDER);
        mac_a       = '0;
        mac_b       = '0;
      end
      default: ;
    endcase
  end

endmodule

`default_nettype wire

/* verilog/result_output.sv */
`timescale 1ns/1ps
`default_nettype none

module result_output import nlc_pkg::*; #(
  parameter int LANES = nlc_pkg::LANES
) (
  input  logic    clk,
  input  logic    reset,
  input  logic    start_emit,
  input  word_t   out_acc,
  output lane_t   out_lane,
  output logic    emit_done,
  output logic    srdyo,
  output sample_t x_lin
);

  localparam lane_t LAST_LANE = lane_t'(LANES - 1);
  localparam word_t SAT_MAX   = word_t'((1 <<< (SAMPLE_WIDTH - 1)) - 1);
  localparam word_t SAT_MIN   = word_t'(-(1 <<< (SAMPLE_WIDTH - 1)));

  logic    busy;
  lane_t   lane;
  word_t   shifted;
  sample_t clamped;

  assign out_lane = lane;
  assign shifted  = out_acc >>> FRAC_BITS;

  always_comb begin
    if (shifted > SAT_MAX) clamped = sample_t'(SAT_MAX);
    else if (shifted < SAT_MIN) clamped = sample_t'(SAT_MIN);
    else clamped = sample_t'(shifted);
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      lane      <= '0;
      srdyo     <= 1'b0;
      emit_done <= 1'b0;
    end else if (start_emit || busy) begin
      srdyo <= 1'b1;
      if (lane == LAST_LANE) begin
        lane      <= '0;
        busy      <= 1'b0;
        emit_done <= 1'b1;  // comes with the last result
      end else begin
        lane      <= lane + 1'b1;
        busy      <= 1'b1;
        emit_done <= 1'b0;
      end
    end else begin
      srdyo     <= 1'b0;
      emit_done <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (start_emit || busy) x_lin <= clamped;
  end

endmodule

`default_nettype wire

/* verilog/nlc_channel.sv */
`timescale 1ns/1ps
`default_nettype none

module nlc_channel import nlc_pkg::*; #(
  parameter int LANES      = nlc_pkg::LANES,
  parameter int POLY_ORDER = nlc_pkg::POLY_ORDER
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          srdyi,
  input  sample_t       x_adc,
  input  section_word_t section_select,
  output logic          ready,
  output logic          srdyo,
  output sample_t       x_lin,
  input  logic          wb_cyc,
  input  logic          wb_stb,
  input  logic          wb_we,
  input  wb_addr_t      wb_adr,
  input  word_t         wb_dat_w,
  output word_t         wb_dat_r,
  output logic          wb_ack
);

  logic         frame_full, frame_done, start_emit, emit_done;
  lane_t        lane_sel, out_lane;
  sample_t      lane_sample;
  section_t     lane_section;
  coeff_index_t coeff_index;
  word_t        coeff, acc, norm, out_acc;
  logic         mac_valid, mac_to_norm, res_valid, res_to_norm;
  word_t        mac_a, mac_b, mac_c, res;
  lane_t        mac_lane, res_lane;

  coeff_regs i_coeff_regs (
    .clk, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
    .rd_section (lane_section),
    .rd_index   (coeff_index),
    .rd_data    (coeff)
  );

  frame_capture #(.LANES(LANES)) i_frame_capture (
    .clk, .reset, .srdyi, .x_adc, .section_select, .frame_done, .ready, .frame_full,
    .lane_sel, .lane_sample, .lane_section
  );

  mul_add_unit i_mul_add_unit (
    .clk, .reset,
    .in_valid    (mac_valid),
    .in_a        (mac_a),
    .in_b        (mac_b),
    .in_c        (mac_c),
    .in_lane     (mac_lane),
    .in_to_norm  (mac_to_norm),
    .out_valid   (res_valid),
    .out_res     (res),
    .out_lane    (res_lane),
    .out_to_norm (res_to_norm)
  );

  lane_regs #(.LANES(LANES)) i_lane_regs (
    .clk,
    .wr_valid   (res_valid),
    .wr_to_norm (res_to_norm),
    .wr_lane    (res_lane),
    .wr_data    (res),
    .rd_lane    (lane_sel),
    .acc, .norm, .out_lane, .out_acc
  );

  horner_sequencer #(.LANES(LANES), .POLY_ORDER(POLY_ORDER)) i_horner_sequencer (
    .clk, .reset, .frame_full, .lane_sample, .coeff, .acc, .norm, .emit_done,
    .lane_sel, .coeff_index, .mac_valid, .mac_to_norm, .mac_a, .mac_b, .mac_c,
    .mac_lane, .start_emit, .frame_done
  );

  result_output #(.LANES(LANES)) i_result_output (
    .clk, .reset, .start_emit, .out_acc, .out_lane, .emit_done, .srdyo, .x_lin
  );

endmodule

`default_nettype wire

/* verification/nlc_channel_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

module nlc_channel_assertions import nlc_pkg::*; #(
  parameter int LANES = nlc_pkg::LANES
) (
  input logic clk,
  input logic reset,
  input logic wb_cyc,
  input logic wb_stb,
  input logic wb_ack,
  input logic srdyo,
  input logic ready
);

  int run_len;  // srdyo cycles so far in this burst

  always_ff @(posedge clk) begin
    if (reset || !srdyo) run_len <= 0;
    else run_len <= run_len + 1;
  end

  ack_follows_request: assert property (@(posedge clk) disable iff (reset)
    wb_ack |-> $past(wb_cyc && wb_stb)) else $error("wb_ack without cyc and stb");

  ack_single_cycle: assert property (@(posedge clk) disable iff (reset)
    wb_ack |=> !wb_ack) else $error("wb_ack high for two cycles");

  burst_length: assert property (@(posedge clk) disable iff (reset)
    srdyo |-> run_len < LANES) else $error("srdyo high for more than LANES cycles");

  no_ready_on_output: assert property (@(posedge clk) disable iff (reset)
    srdyo |-> !ready) else $error("ready high while srdyo is high");

endmodule

bind nlc_channel nlc_channel_assertions #(.LANES(LANES)) i_assertions (
  .clk(clk), .reset(reset), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
  .srdyo(srdyo), .ready(ready)
);

`default_nettype wire

/* verification/nlc_channel_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module nlc_channel_tb import nlc_pkg::*; ();

  localparam int LIMIT   = 500;
  localparam int LATENCY = (3 + POLY_ORDER) * LANES + MAC_LATENCY + 2;
  localparam int SAT_HI  = 2 ** (SAMPLE_WIDTH - 1) - 1;

  logic          clk = 1'b0;
  logic          reset, srdyi, ready, srdyo;
  logic          wb_cyc, wb_stb, wb_we, wb_ack;
  sample_t       x_adc, x_lin;
  section_word_t section_select;
  wb_addr_t      wb_adr;
  word_t         wb_dat_w, wb_dat_r;

  logic [31:0]   lfsr = 32'h9448_0496;
  int            cal [SECTIONS][16];  // indexed like the bus address
  int            errors = 0;
  int            test_errs = 0;
  int            tests = 0;
  logic          hung = 1'b0;
  sample_t       samples [LANES];
  section_word_t sec_word;
  longint        t_last;

  nlc_channel i_dut (.*);

  always #20 clk = ~clk;

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic int random_signed(input int n);
    return int'(random_bits(n) << (32 - n)) >>> (32 - n);
  endfunction

  // product shifted down, truncated, then c added with 32-bit wrap
  function automatic int mac(input int a, input int b, input int c);
    longint p;
    p = (longint'(a) * longint'(b)) >>> FRAC_BITS;
    return int'(p) + c;
  endfunction

  function automatic sample_t expected(input sample_t x, input section_t s);
    int acc;
    int norm;
    int y;
    acc  = mac(int'(x), FIX_ONE, cal[s][14]);
    norm = mac(acc, cal[s][15], 0);
    acc  = mac(0, 0, cal[s][POLY_ORDER]);
    for (int k = POLY_ORDER - 1; k >= 0; k--) acc = mac(acc, norm, cal[s][k]);
    y = acc >>> FRAC_BITS;
    if (y > SAT_HI) y = SAT_HI;
    else if (y < -SAT_HI - 1) y = -SAT_HI - 1;
    return sample_t'(y);
  endfunction

  // which is 0 for wb_ack, 1 for ready, 2 for srdyo
  task automatic wait_for(input int which, input string what);
    int n;
    if (hung) return;
    for (n = 0; n < LIMIT; n++) begin
      @(negedge clk);
      if ((which == 0 && wb_ack) || (which == 1 && ready) || (which == 2 && srdyo)) break;
    end
    if (n == LIMIT) begin
      $display("timeout: no %s within %0d cycles", what, LIMIT);
      hung = 1'b1;
      test_errs++;
    end
  endtask

  task automatic wb_xfer(input logic we, input wb_addr_t adr, input word_t dat,
                         output word_t rd);
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= dat;
    wait_for(0, "wishbone ack");
    rd = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
  endtask

  // mode 0 random words, 1 identity, 2 bounded random, 3 large
  task automatic load_cal(input int mode);
    word_t v;
    word_t rd;
    int    idx;
    for (int a = 0; a < 64; a++) begin
      idx = a % 16;
      case (mode)
        1: v = (idx == 1 || idx == 15) ? FIX_ONE : '0;
        2: begin
          if (idx == 15) v = word_t'(random_bits(12));
          else v = word_t'(random_signed(idx == 14 ? 20 : 14));
        end
        3: v = word_t'(random_signed(idx == 15 ? 20 : 31));
        default: v = word_t'(random_bits(32));
      endcase
      wb_xfer(1'b1, wb_addr_t'(a), v, rd);
      cal[a / 16][idx] = (idx <= POLY_ORDER || idx >= 14) ? int'(v) : 0;
    end
  endtask

  task automatic send_frame(input int junk);
    for (int i = 0; i < LANES; i++) samples[i] = sample_t'(random_bits(SAMPLE_WIDTH));
    sec_word = section_word_t'(random_bits(2 * LANES));
    wait_for(1, "ready");
    for (int i = 0; i < LANES; i++) begin
      @(posedge clk);
      srdyi          <= 1'b1;
      x_adc          <= samples[i];
      section_select <= (i == 0) ? sec_word : ~sec_word;  // only the first counts
      t_last = $time;
    end
    for (int i = 0; i < junk; i++) begin
      @(posedge clk);
      x_adc <= sample_t'(random_bits(SAMPLE_WIDTH));  // ready is low by now
    end
    @(posedge clk);
    srdyi <= 1'b0;
  endtask

  task automatic check_frame(input string name);
    sample_t exp;
    longint  lat;
    wait_for(2, "srdyo");
    if (hung) return;
    lat = ($time - t_last - 20) / 40;
    if (lat != LATENCY) begin
      $display("ERR %s latency: expected %0d, actual %0d", name, LATENCY, lat);
      test_errs++;
    end
    for (int i = 0; i < LANES; i++) begin
      if (i > 0) @(negedge clk);
      exp = expected(samples[i], sec_word[2 * (LANES - 1 - i) +: 2]);
      if (!srdyo) begin
        $display("%s: srdyo went low after only %0d results", name, i);
        test_errs++;
      end else if (x_lin !== exp) begin
        $display("ERR %s lane %0d: expected %0d, actual %0d", name, i, exp, x_lin);
        test_errs++;
      end
    end
    @(negedge clk);
    if (srdyo || !ready) begin
      $display("%s: srdyo still high or ready not back after %0d results", name, LANES);
      test_errs++;
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    errors += test_errs;
    $display("test %s: %0d errors", name, test_errs);
    test_errs = 0;
  endtask

  task automatic run_frames(input string name, input int frames, input int junk);
    for (int f = 0; f < frames; f++) begin
      send_frame(junk);
      check_frame(name);
    end
    end_test(name);
  endtask

  initial begin
    word_t rd;
    reset          = 1'b1;
    srdyi          = 1'b0;
    x_adc          = '0;
    section_select = '0;
    wb_cyc         = 1'b0;
    wb_stb         = 1'b0;
    wb_we          = 1'b0;
    wb_adr         = '0;
    wb_dat_w       = '0;
    repeat (3) @(posedge clk);
    reset <= 1'b0;

    load_cal(0);
    for (int a = 0; a < 64; a++) begin
      wb_xfer(1'b0, wb_addr_t'(a), '0, rd);
      if (rd !== word_t'(cal[a / 16][a % 16])) begin
        $display("ERR registers addr %0d: expected %h, actual %h", a, cal[a / 16][a % 16], rd);
        test_errs++;
      end
    end
    end_test("registers");

    load_cal(1);
    run_frames("identity", 2, 0);
    load_cal(2);
    run_frames("random", 6, 0);
    load_cal(3);
    run_frames("saturation", 4, 0);
    load_cal(2);
    run_frames("discipline", 3, 5);  // extra srdyi cycles after each frame

    $display("%0d tests run, %0d errors", tests, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* src.f */
verilog/nlc_pkg.sv
verilog/coeff_regs.sv
verilog/frame_capture.sv
verilog/mul_add_unit.sv
verilog/lane_regs.sv
verilog/horner_sequencer.sv
verilog/result_output.sv
verilog/nlc_channel.sv
verification/nlc_channel_assertions.sv
verification/nlc_channel_tb.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the nlc_channel testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module nlc_channel_tb -f src.f -o nlc_sim
./obj_dir/nlc_sim > sim.log 2>&1 || true
cat sim.log
grep -q "Finished with no errors" sim.log
